//--- compile.f
+incdir+.
trap_pkg.sv
csr_bus.sv
csr_file.sv
trap_dispatch.sv
machine_timer.sv
trap_unit.sv
tb_clock.sv
trap_unit_tb.sv

//--- csr_bus.sv
// Wishbone CSR and timer front end
`timescale 1ns/10ps
`default_nettype none
`include "trap_settings.svh"

module csr_bus (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  wb_cyc,
    input  wire logic                  wb_stb,
    input  wire logic                  wb_we,
    input  wire logic [`WB_ADR_W-1:0]  wb_adr,
    input  wire logic [`XLEN-1:0]      wb_dat_w,
    input  wire logic [`XLEN-1:0]      csr_rdata,
    input  wire trap_pkg::access_e     csr_access,
    input  wire logic [`XLEN-1:0]      tmr_rdata,
    output logic      [`XLEN-1:0]      wb_dat_r,
    output logic                       wb_ack,
    output logic                       wb_err,
    output logic      [11:0]           csr_addr,
    output logic                       csr_we,
    output logic      [`XLEN-1:0]      csr_wdata,
    output logic                       tmr_sel,
    output logic                       tmr_we,
    output logic      [1:0]            tmr_word
);
    trap_pkg::bus_state_e state;
    logic commit;
    logic acc_ok;

    // Top address bit picks the timer region.
    assign tmr_sel   = wb_adr[`WB_ADR_W-1];
    assign tmr_word  = wb_adr[1:0];
    assign csr_addr  = wb_adr[11:0];
    assign csr_wdata = wb_dat_w;

    // Request seen while idle, answered at the next edge.
    assign commit = (state == trap_pkg::BUS_IDLE) && wb_cyc && wb_stb;

    // Reads of read-only CSRs are fine, writes are not.
    // Timer words always exist.
    assign acc_ok = tmr_sel ||
                    (csr_access == trap_pkg::ACC_OK) ||
                    ((csr_access == trap_pkg::ACC_RDONLY) && !wb_we);

    // Write strobes only on the committing cycle.
    assign csr_we = commit && wb_we && !tmr_sel && (csr_access == trap_pkg::ACC_OK);
    assign tmr_we = commit && wb_we && tmr_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= trap_pkg::BUS_IDLE;
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
        end else if (commit) begin
            state  <= trap_pkg::BUS_ACK;
            wb_ack <= acc_ok;
            wb_err <= !acc_ok;
        end else begin
            // One cycle of ack, then idle again.
            state  <= trap_pkg::BUS_IDLE;
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
        end
    end

    // Read data held with the ack.
    always_ff @(posedge clk) begin
        if (commit) begin
            wb_dat_r <= tmr_sel ? tmr_rdata : csr_rdata;
        end
    end
endmodule

`default_nettype wire

//--- csr_file.sv
// Machine-mode CSR file
`timescale 1ns/10ps
`default_nettype none
`include "trap_settings.svh"

module csr_file (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [11:0]       csr_addr,
    input  wire logic              csr_we,
    input  wire logic [`XLEN-1:0]  csr_wdata,
    input  wire trap_pkg::trap_event_e ev,
    input  wire logic [4:0]        ev_cause,
    input  wire logic [`XLEN-1:1]  ev_epc,
    input  wire logic [`XLEN-1:0]  ip_bits,
    output logic      [`XLEN-1:0]  csr_rdata,
    output trap_pkg::access_e      csr_access,
    output logic                   mstatus_mie,
    output logic      [`XLEN-1:0]  mie_bits,
    output logic      [`XLEN-1:2]  mtvec,
    output logic      [`XLEN-1:1]  mepc
);
    // Stored fields.
    logic             mstatus_mpie;
    logic [`XLEN-1:0] mscratch;
    logic             mcause_int;
    logic [4:0]       mcause_no;

    // Assembled CSR words.
    logic [`XLEN-1:0] mstatus_word;
    logic [`XLEN-1:0] mcause_word;
    logic [`XLEN-1:0] mip_word;
    logic             trap_entry;

    always_comb begin
        mstatus_word    = '0;
        mstatus_word[3] = mstatus_mie;
        mstatus_word[7] = mstatus_mpie;
    end

    assign mcause_word = {mcause_int, {(`XLEN-6){1'b0}}, mcause_no};

    // Pending bits only show where enabled.
    assign mip_word = ip_bits & mie_bits;

    // Interrupts and traps share the entry sequence.
    assign trap_entry = (ev == trap_pkg::EV_IRQ) || (ev == trap_pkg::EV_TRAP);

    // Read mux and access check.
    always_comb begin
        csr_access = trap_pkg::ACC_OK;
        csr_rdata  = '0;
        case (csr_addr)
            `CSR_MSTATUS:  csr_rdata = mstatus_word;
            `CSR_MIE:      csr_rdata = mie_bits;
            `CSR_MTVEC:    csr_rdata = {mtvec, 2'b00};
            `CSR_MSCRATCH: csr_rdata = mscratch;
            `CSR_MEPC:     csr_rdata = {mepc, 1'b0};
            `CSR_MCAUSE:   csr_rdata = mcause_word;
            `CSR_MIP:      csr_rdata = mip_word;
            `CSR_MISA: begin
                csr_access = trap_pkg::ACC_RDONLY;
                csr_rdata  = `MISA_VALUE;
            end
            `CSR_MARCHID: begin
                csr_access = trap_pkg::ACC_RDONLY;
                csr_rdata  = `MARCHID_VALUE;
            end
            `CSR_MHARTID: begin
                csr_access = trap_pkg::ACC_RDONLY;
                csr_rdata  = `HART_ID;
            end
            default: csr_access = trap_pkg::ACC_NONE;
        endcase
    end

    // Trap entry wins over a bus write, a bus write over MRET.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_bits     <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_no    <= '0;
        end else if (trap_entry) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mepc         <= ev_epc;
            mcause_int   <= (ev == trap_pkg::EV_IRQ);
            mcause_no    <= ev_cause;
        end else if (csr_we) begin
            case (csr_addr)
                `CSR_MSTATUS: begin
                    mstatus_mie  <= csr_wdata[3];
                    mstatus_mpie <= csr_wdata[7];
                end
                `CSR_MIE:      mie_bits <= csr_wdata;
                `CSR_MTVEC:    mtvec    <= csr_wdata[`XLEN-1:2];
                `CSR_MSCRATCH: mscratch <= csr_wdata;
                `CSR_MEPC:     mepc     <= csr_wdata[`XLEN-1:1];
                `CSR_MCAUSE: begin
                    mcause_int <= csr_wdata[`XLEN-1];
                    mcause_no  <= csr_wdata[4:0];
                end
                default: ;
            endcase
        end else if (ev == trap_pkg::EV_RET) begin
            // MRET restores the enable.
            mstatus_mie <= mstatus_mpie;
        end
    end
endmodule

`default_nettype wire

//--- machine_timer.sv
// Machine timer
`timescale 1ns/10ps
`default_nettype none
`include "trap_settings.svh"

module machine_timer (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              tmr_sel,
    input  wire logic              tmr_we,
    input  wire logic [1:0]        tmr_word,
    input  wire logic [`XLEN-1:0]  wdata,
    output logic      [`XLEN-1:0]  tmr_rdata,
    output logic                   timer_irq
);
    logic [2*`XLEN-1:0] mtime;
    logic [2*`XLEN-1:0] mtimecmp;
    logic               wr;

    assign wr = tmr_sel && tmr_we;

    // Counts clk cycles. A write replaces the increment.
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            if (wr && tmr_word == `TMR_MTIME_LO) begin
                mtime[`XLEN-1:0] <= wdata;
            end else if (wr && tmr_word == `TMR_MTIME_HI) begin
                mtime[2*`XLEN-1:`XLEN] <= wdata;
            end else begin
                mtime <= mtime + 1'b1;
            end
            // Compare value, one word at a time.
            if (wr && tmr_word == `TMR_MTIMECMP_LO) begin
                mtimecmp[`XLEN-1:0] <= wdata;
            end
            if (wr && tmr_word == `TMR_MTIMECMP_HI) begin
                mtimecmp[2*`XLEN-1:`XLEN] <= wdata;
            end
        end
    end

    // Word read mux.
    always_comb begin
        case (tmr_word)
            `TMR_MTIME_LO:    tmr_rdata = mtime[`XLEN-1:0];
            `TMR_MTIME_HI:    tmr_rdata = mtime[2*`XLEN-1:`XLEN];
            `TMR_MTIMECMP_LO: tmr_rdata = mtimecmp[`XLEN-1:0];
            default:          tmr_rdata = mtimecmp[2*`XLEN-1:`XLEN];
        endcase
    end

    // Unsigned compare, level output.
    assign timer_irq = (mtime >= mtimecmp);
endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the trap unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    --top-module trap_unit_tb -f compile.f

./obj_dir/Vtrap_unit_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim.sh: failures found in sim.log"
    exit 1
fi
echo "run_sim.sh: no failures in sim.log"
exit 0

//--- tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    // 10 ns period.
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset over eight rising edges, released on a falling edge.
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end
endmodule

`default_nettype wire

//--- trap_dispatch.sv
// Interrupt and trap dispatch
`timescale 1ns/10ps
`default_nettype none
`include "trap_settings.svh"

module trap_dispatch (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [`XLEN-1:`IRQ_EXT_LO]  irq,
    input  wire logic                        timer_irq,
    input  wire logic                        mstatus_mie,
    input  wire logic [`XLEN-1:0]            mie_bits,
    input  wire logic                        retire_valid,
    input  wire logic [`XLEN-1:1]            retire_pc,
    input  wire logic                        trap_req,
    input  wire logic [3:0]                  trap_cause,
    input  wire logic                        mret,
    output trap_pkg::trap_event_e            ev,
    output logic      [4:0]                  ev_cause,
    output logic      [`XLEN-1:1]            ev_epc,
    output logic      [`XLEN-1:0]            ip_bits,
    output logic                             trap_taken
);
    logic [`XLEN-1:0]     ip_next;
    logic [`XLEN-1:0]     irq_mask;
    logic [`MIE_DELAY-1:0] mie_hist;
    logic                 irq_en;
    logic                 irq_pend;
    logic [4:0]           irq_cause;

    // Map sources onto their mip positions.
    always_comb begin
        ip_next                        = '0;
        ip_next[`XLEN-1:`IRQ_EXT_LO]   = irq;
        ip_next[`IRQ_TIMER]            = timer_irq;
    end

    // Pending latch and MIE history.
    always_ff @(posedge clk) begin
        if (rst) begin
            ip_bits  <= '0;
            mie_hist <= '0;
        end else begin
            ip_bits  <= ip_next;
            mie_hist <= {mie_hist[`MIE_DELAY-2:0], mstatus_mie};
        end
    end

    // MIE must have held for the whole delay.
    assign irq_en = (&mie_hist) && mstatus_mie;

    // Bit 0 never interrupts.
    assign irq_mask = ip_bits & mie_bits & ~`XLEN'(1);
    assign irq_pend = |irq_mask;

    // Walk downwards so the lowest number wins.
    always_comb begin
        irq_cause = '0;
        for (int i = `XLEN-1; i > 0; i--) begin
            if (irq_mask[i]) begin
                irq_cause = 5'(i);
            end
        end
    end

    assign ev_epc = retire_pc;

    // Interrupt beats trap, MRET only when nothing else fires.
    always_comb begin
        ev       = trap_pkg::EV_NONE;
        ev_cause = '0;
        if (retire_valid && irq_en && irq_pend) begin
            ev       = trap_pkg::EV_IRQ;
            ev_cause = irq_cause;
        end else if (retire_valid && trap_req) begin
            ev       = trap_pkg::EV_TRAP;
            ev_cause = {1'b0, trap_cause};
        end else if (retire_valid && mret) begin
            ev       = trap_pkg::EV_RET;
        end
    end

    assign trap_taken = (ev == trap_pkg::EV_IRQ) || (ev == trap_pkg::EV_TRAP);
endmodule

`default_nettype wire

//--- trap_pkg.sv
// Trap unit types
`default_nettype none

package trap_pkg;

    // What the CSR file does this cycle.
    typedef enum logic [1:0] {
        EV_NONE,
        EV_IRQ,
        EV_TRAP,
        EV_RET
    } trap_event_e;

    // Wishbone front end state.
    typedef enum logic {
        BUS_IDLE,
        BUS_ACK
    } bus_state_e;

    // Result of a CSR address lookup.
    typedef enum logic [1:0] {
        ACC_OK,
        ACC_NONE,
        ACC_RDONLY
    } access_e;

endpackage

`default_nettype wire

//--- trap_settings.svh
// Trap unit settings
`ifndef TRAP_SETTINGS_SVH
`define TRAP_SETTINGS_SVH

// Data path and bus widths.
`define XLEN              32
`define WB_ADR_W          13

// Machine-mode CSR numbers.
`define CSR_MSTATUS       12'h300
`define CSR_MISA          12'h301
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MSCRATCH      12'h340
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MIP           12'h344
`define CSR_MARCHID       12'hf12
`define CSR_MHARTID       12'hf14

// Timer word offsets.
`define TMR_MTIME_LO      2'd0
`define TMR_MTIME_HI      2'd1
`define TMR_MTIMECMP_LO   2'd2
`define TMR_MTIMECMP_HI   2'd3

// Identity words. RV32I, MXL 01.
`define MISA_VALUE        32'h4000_0100
`define MARCHID_VALUE     32'd37
`define HART_ID           32'd0

// Interrupt numbering and enable delay.
`define IRQ_EXT_LO        16
`define IRQ_TIMER         7
`define MIE_DELAY         2

`endif

//--- trap_unit.sv
// Trap and CSR unit top level
`timescale 1ns/10ps
`default_nettype none
`include "trap_settings.svh"

module trap_unit (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        wb_cyc,
    input  wire logic                        wb_stb,
    input  wire logic                        wb_we,
    input  wire logic [`WB_ADR_W-1:0]        wb_adr,
    input  wire logic [`XLEN-1:0]            wb_dat_w,
    output logic      [`XLEN-1:0]            wb_dat_r,
    output logic                             wb_ack,
    output logic                             wb_err,
    input  wire logic                        retire_valid,
    input  wire logic [`XLEN-1:1]            retire_pc,
    input  wire logic                        trap_req,
    input  wire logic [3:0]                  trap_cause,
    input  wire logic                        mret,
    input  wire logic [`XLEN-1:`IRQ_EXT_LO]  irq,
    output logic                             trap_taken,
    output logic      [`XLEN-1:2]            trap_vector,
    output logic      [`XLEN-1:1]            ret_pc
);
    // Bus to CSR file and timer.
    logic [11:0]           csr_addr;
    logic                  csr_we;
    logic [`XLEN-1:0]      csr_wdata;
    logic [`XLEN-1:0]      csr_rdata;
    trap_pkg::access_e     csr_access;
    logic                  tmr_sel;
    logic                  tmr_we;
    logic [1:0]            tmr_word;
    logic [`XLEN-1:0]      tmr_rdata;
    // Dispatch to CSR file and back.
    trap_pkg::trap_event_e ev;
    logic [4:0]            ev_cause;
    logic [`XLEN-1:1]      ev_epc;
    logic [`XLEN-1:0]      ip_bits;
    logic                  mstatus_mie;
    logic [`XLEN-1:0]      mie_bits;
    logic                  timer_irq;

    csr_bus bus0 (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .csr_rdata, .csr_access, .tmr_rdata,
        .wb_dat_r, .wb_ack, .wb_err,
        .csr_addr, .csr_we, .csr_wdata, .tmr_sel, .tmr_we, .tmr_word
    );

    // Trap vector and return PC come straight from the CSRs.
    csr_file csrs0 (
        .clk, .rst, .csr_addr, .csr_we, .csr_wdata,
        .ev, .ev_cause, .ev_epc, .ip_bits,
        .csr_rdata, .csr_access, .mstatus_mie, .mie_bits,
        .mtvec(trap_vector), .mepc(ret_pc)
    );

    trap_dispatch disp0 (
        .clk, .rst, .irq, .timer_irq, .mstatus_mie, .mie_bits,
        .retire_valid, .retire_pc, .trap_req, .trap_cause, .mret,
        .ev, .ev_cause, .ev_epc, .ip_bits, .trap_taken
    );

    machine_timer tmr0 (
        .clk, .rst, .tmr_sel, .tmr_we, .tmr_word,
        .wdata(csr_wdata), .tmr_rdata, .timer_irq
    );
endmodule

`default_nettype wire

//--- trap_unit_tb.sv
// Trap unit testbench
`timescale 1ns/10ps
`default_nettype none
`include "trap_settings.svh"

module trap_unit_tb;
    localparam int BUS_TIMEOUT  = 20;
    localparam int TRAP_TIMEOUT = 200;
    localparam int RST_TIMEOUT  = 50;

    typedef enum logic [2:0] {OP_WRITE, OP_WRITE_REL, OP_READ, OP_RETIRE, OP_WAIT_TRAP} op_e;
    // Equal, bus error, no value check, above the previous read.
    typedef enum logic [1:0] {CK_EQ, CK_ERR, CK_SKIP, CK_GT} chk_e;

    typedef struct {
        op_e              op;
        logic [12:0]      adr;
        logic [`XLEN-1:0] data;
        logic [`XLEN-1:0] exp;
        chk_e             chk;
        string            name;
    } row_t;

    logic                       clk;
    logic                       rst;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [`WB_ADR_W-1:0]       wb_adr;
    logic [`XLEN-1:0]           wb_dat_w;
    logic [`XLEN-1:0]           wb_dat_r;
    logic                       wb_ack;
    logic                       wb_err;
    logic                       retire_valid;
    logic [`XLEN-1:1]           retire_pc;
    logic                       trap_req;
    logic [3:0]                 trap_cause;
    logic                       mret;
    logic [`XLEN-1:`IRQ_EXT_LO] irq;
    logic                       trap_taken;
    logic [`XLEN-1:2]           trap_vector;
    logic [`XLEN-1:1]           ret_pc;

    row_t             rows[$];
    int               checks;
    int               errors;
    int               waited;
    logic [`XLEN-1:0] last_read;
    logic [`XLEN-1:0] rdata;
    logic [`XLEN-1:0] wdata;
    logic             err_seen;
    logic             ack_seen;
    logic             taken;
    logic [`XLEN-1:0] vec;
    logic [`XLEN-1:0] rpc;
    logic [`XLEN-1:0] rnd_scratch;
    logic [`XLEN-1:0] rnd_vec;
    logic [`XLEN-1:0] rnd_epc;
    logic [`XLEN-1:0] trap_pc;
    logic [`XLEN-1:0] vec_exp;

    tb_clock clk0 (.clk, .rst);
    trap_unit dut0 (.*);

    function automatic logic [12:0] csr_adr(input logic [11:0] num);
        return {1'b0, num};
    endfunction

    function automatic logic [12:0] tmr_adr(input logic [1:0] word);
        return {1'b1, 10'd0, word};
    endfunction

    // Retire row code: bit 5 MRET, bit 4 trap request, bits 3..0 cause.
    function automatic logic [12:0] retire_code(input logic m, input logic t,
                                                input logic [3:0] c);
        return {7'd0, m, t, c};
    endfunction

    function automatic row_t make_row(input op_e op, input logic [12:0] adr,
                                      input logic [31:0] data, input logic [31:0] exp,
                                      input chk_e chk, input string name);
        row_t r;
        r.op   = op;
        r.adr  = adr;
        r.data = data;
        r.exp  = exp;
        r.chk  = chk;
        r.name = name;
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // One Wishbone classic cycle, held until ack or err.
    task automatic bus_xfer(input logic we, input logic [12:0] adr, input logic [31:0] wd,
                            output logic [31:0] rd, output logic err_out,
                            output logic ack_out);
        int n;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wd;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && !wb_err && n < BUS_TIMEOUT);
        if (!wb_ack && !wb_err) begin
            $display("Timeout: bus gave no ack or err at address %h", adr);
            errors++;
        end
        rd      = wb_dat_r;
        err_out = wb_err;
        ack_out = wb_ack;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
    endtask

    // One retiring instruction, outputs sampled mid low phase.
    task automatic retire(input logic [31:0] pc, input logic t, input logic [3:0] c,
                          input logic m, output logic tk, output logic [31:0] v,
                          output logic [31:0] rp);
        @(negedge clk);
        retire_valid = 1'b1;
        retire_pc    = pc[`XLEN-1:1];
        trap_req     = t;
        trap_cause   = c;
        mret         = m;
        #2;
        tk = trap_taken;
        v  = {trap_vector, 2'b00};
        rp = {ret_pc, 1'b0};
        @(negedge clk);
        retire_valid = 1'b0;
        trap_req     = 1'b0;
        mret         = 1'b0;
    endtask

    // Drives irq, then retires plain instructions until one is trapped.
    task automatic wait_trap(input logic [31:0] irq_word, input string name,
                             output logic [31:0] v);
        logic             tk;
        logic [`XLEN-1:0] rp;
        int               tries;
        @(negedge clk);
        irq   = irq_word[`XLEN-1:`IRQ_EXT_LO];
        tk    = 1'b0;
        tries = 0;
        v     = '0;
        while (!tk && tries < TRAP_TIMEOUT) begin
            retire($urandom & ~32'd1, 1'b0, 4'd0, 1'b0, tk, v, rp);
            tries++;
        end
        if (!tk) begin
            $display("Timeout: %s saw no trap after %0d retires", name, tries);
            errors++;
        end
    endtask

    task automatic build_table();
        // Reset values and identity.
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MSTATUS), 0, 0, CK_EQ, "rst_mstatus"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MCAUSE), 0, 0, CK_EQ, "rst_mcause"));
        rows.push_back(make_row(OP_READ, tmr_adr(`TMR_MTIMECMP_LO), 0, 32'hffff_ffff,
                                CK_EQ, "rst_mtimecmp"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MHARTID), 0, 32'd0, CK_EQ, "mhartid"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MISA), 0, 32'h4000_0100, CK_EQ, "misa"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MARCHID), 0, 32'd37, CK_EQ, "marchid"));
        rows.push_back(make_row(OP_WRITE, csr_adr(`CSR_MISA), $urandom, 0, CK_ERR, "misa_wr"));
        rows.push_back(make_row(OP_READ, csr_adr(12'h7c0), 0, 0, CK_ERR, "no_csr"));
        // Write masks.
        rows.push_back(make_row(OP_WRITE, csr_adr(`CSR_MSCRATCH), rnd_scratch, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MSCRATCH), 0, rnd_scratch, CK_EQ,
                                "mscratch"));
        rows.push_back(make_row(OP_WRITE, csr_adr(`CSR_MTVEC), rnd_vec, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MTVEC), 0, vec_exp, CK_EQ, "mtvec"));
        rows.push_back(make_row(OP_WRITE, csr_adr(`CSR_MEPC), rnd_epc, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MEPC), 0, rnd_epc & ~32'd1, CK_EQ, "mepc"));
        rows.push_back(make_row(OP_WRITE, csr_adr(`CSR_MSTATUS), 32'hffff_ffff, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MSTATUS), 0, 32'h88, CK_EQ, "mstatus"));
        // Trap with MIE 1 and MPIE 0, then MRET.
        rows.push_back(make_row(OP_WRITE, csr_adr(`CSR_MSTATUS), 32'h8, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_RETIRE, retire_code(1'b0, 1'b1, 4'd2), trap_pc, vec_exp,
                                CK_EQ, "trap"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MEPC), 0, trap_pc, CK_EQ, "trap_mepc"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MCAUSE), 0, 32'd2, CK_EQ, "trap_mcause"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MSTATUS), 0, 32'h80, CK_EQ, "trap_mst"));
        rows.push_back(make_row(OP_RETIRE, retire_code(1'b1, 1'b0, 4'd0), trap_pc + 4, trap_pc,
                                CK_EQ, "mret"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MSTATUS), 0, 32'h88, CK_EQ, "mret_mst"));
        // External interrupts 20 and 25 enabled, 16 pending but masked.
        rows.push_back(make_row(OP_WRITE, csr_adr(`CSR_MIE), 32'h0210_0000, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_WAIT_TRAP, 0, 32'h0211_0000, vec_exp, CK_EQ, "ext_irq"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MCAUSE), 0, 32'h8000_0014, CK_EQ,
                                "ext_mcause"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MIP), 0, 32'h0210_0000, CK_EQ, "ext_mip"));
        // Timer interrupt 20 ticks ahead.
        rows.push_back(make_row(OP_WRITE, csr_adr(`CSR_MIE), 32'h80, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_WRITE, csr_adr(`CSR_MSTATUS), 32'h8, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_WRITE, tmr_adr(`TMR_MTIMECMP_HI), 0, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_READ, tmr_adr(`TMR_MTIME_LO), 0, 0, CK_SKIP, "mtime0"));
        rows.push_back(make_row(OP_READ, tmr_adr(`TMR_MTIME_LO), 0, 0, CK_GT, "mtime1"));
        rows.push_back(make_row(OP_WRITE_REL, tmr_adr(`TMR_MTIMECMP_LO), 32'd20, 0, CK_EQ, "wr"));
        rows.push_back(make_row(OP_WAIT_TRAP, 0, 0, vec_exp, CK_EQ, "tmr_irq"));
        rows.push_back(make_row(OP_READ, csr_adr(`CSR_MCAUSE), 0, 32'h8000_0007, CK_EQ,
                                "tmr_mcause"));
    endtask

    initial begin
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        retire_valid = 1'b0;
        retire_pc    = '0;
        trap_req     = 1'b0;
        trap_cause   = '0;
        mret         = 1'b0;
        irq          = '0;
        checks       = 0;
        errors       = 0;
        last_read    = '0;
        void'($urandom(32'hcdad_b8ff));
        rnd_scratch = $urandom;
        rnd_vec     = $urandom;
        rnd_epc     = $urandom;
        trap_pc     = $urandom & ~32'd1;
        vec_exp     = rnd_vec & ~32'd3;
        build_table();

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (rst && waited < RST_TIMEOUT);
        if (rst) begin
            $display("Timeout: reset never released");
            errors++;
        end

        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WRITE, OP_WRITE_REL: begin
                    wdata = rows[i].data;
                    if (rows[i].op == OP_WRITE_REL) begin
                        wdata = last_read + rows[i].data;
                    end
                    bus_xfer(1'b1, rows[i].adr, wdata, rdata, err_seen, ack_seen);
                    check_val({rows[i].name, " err"}, 32'(rows[i].chk == CK_ERR),
                              32'(err_seen));
                    check_val({rows[i].name, " ack"}, 32'(rows[i].chk != CK_ERR),
                              32'(ack_seen));
                end
                OP_READ: begin
                    bus_xfer(1'b0, rows[i].adr, '0, rdata, err_seen, ack_seen);
                    check_val({rows[i].name, " err"}, 32'(rows[i].chk == CK_ERR),
                              32'(err_seen));
                    check_val({rows[i].name, " ack"}, 32'(rows[i].chk != CK_ERR),
                              32'(ack_seen));
                    if (rows[i].chk == CK_EQ) begin
                        check_val(rows[i].name, rows[i].exp, rdata);
                    end
                    // Counter must have moved on.
                    if (rows[i].chk == CK_GT) begin
                        checks++;
                        if (rdata <= last_read) begin
                            $display("Fail %s expected above %h actual %h",
                                     rows[i].name, last_read, rdata);
                            errors++;
                        end
                    end
                    last_read = rdata;
                end
                OP_RETIRE: begin
                    retire(rows[i].data, rows[i].adr[4], rows[i].adr[3:0], rows[i].adr[5],
                           taken, vec, rpc);
                    check_val({rows[i].name, " taken"}, 32'(rows[i].adr[4]), 32'(taken));
                    if (rows[i].adr[4]) begin
                        check_val({rows[i].name, " vector"}, rows[i].exp, vec);
                    end
                    if (rows[i].adr[5]) begin
                        check_val({rows[i].name, " ret_pc"}, rows[i].exp, rpc);
                    end
                end
                OP_WAIT_TRAP: begin
                    wait_trap(rows[i].data, rows[i].name, vec);
                    check_val({rows[i].name, " vector"}, rows[i].exp, vec);
                end
                default: begin
                    $display("Table row %0d holds an unknown operation", i);
                    errors++;
                end
            endcase
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

`default_nettype wire
